// ==== Makefile ====
SOURCES = $(shell grep -v '^+' build.f) include/hb_settings.svh

.PHONY: all run clean

all: run

obj_dir/Vhb_ctrl_tb: build.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ps --top-module hb_ctrl_tb -f build.f

run: obj_dir/Vhb_ctrl_tb
	./obj_dir/Vhb_ctrl_tb | tee sim.log
	grep -qx 'test passed' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
+incdir+include
logic/hb_pkg.sv
logic/hb_config_if.sv
logic/hb_status_if.sv
logic/hb_reg_block.sv
logic/hb_sequencer.sv
logic/hb_tx_path.sv
logic/hb_rx_path.sv
logic/hb_ctrl_top.sv
test/hb_mem_model.sv
test/hb_ctrl_tb.sv

// ==== include/hb_settings.svh ====
`ifndef HB_SETTINGS_SVH
`define HB_SETTINGS_SVH

`define HB_ADDR_W      32
`define HB_DATA_W      32
`define HB_TIMING_W    4

// Bus beats per phase, two bytes per beat
`define HB_CA_BEATS    3
`define HB_DATA_BEATS  2

// Register byte offsets
`define HB_REG_MBR     8'h00
`define HB_REG_MTR     8'h04
`define HB_REG_STS     8'h08

`define HB_MBR_RESET   32'h0000_0000
`define HB_MTR_RESET   32'h1111_1106

`endif

// ==== logic/hb_config_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface hb_config_if import hb_pkg::*; ();
   logic [7:0] base;             // Matches address bits 31..24
   timing_t    rd_css, rd_csh, rd_cshi;
   timing_t    wr_css, wr_csh, wr_cshi;
   timing_t    latency;

   modport regs (output base, rd_css, rd_csh, rd_cshi, wr_css, wr_csh, wr_cshi,
                 latency);
   modport seq  (input base, rd_css, rd_csh, rd_cshi, wr_css, wr_csh, wr_cshi,
                 latency);
endinterface

`default_nettype wire

// ==== logic/hb_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hb_ctrl_top import hb_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   // Memory request port
   input  logic       mem_req,
   input  logic       mem_we,
   input  mem_addr_t  mem_addr,
   input  mem_word_t  mem_wdata,
   input  byte_strb_t mem_wstrb,
   output logic       mem_busy,
   output logic       mem_done,
   output logic       mem_err,
   output mem_word_t  mem_rdata,
   // Register port
   input  logic       reg_wr,
   input  logic       reg_rd,
   input  logic [7:0] reg_addr,
   input  mem_word_t  reg_wdata,
   output mem_word_t  reg_rdata,
   // HyperBus pins
   input  logic [7:0] dq_in,
   input  logic       rwds_in,
   output logic       cs0n,
   output logic       ck_en,
   output logic       dq_out_en,
   output logic [7:0] dq_out0,
   output logic [7:0] dq_out1,
   output logic       wds_en,
   output logic       wds0,
   output logic       wds1
);
   logic load, ca_step, data_step, data_sel;
   logic capture, word_full;

   hb_config_if cfg_if ();
   hb_status_if sts_if ();

   // ----------------------------------------
   hb_reg_block u_regs (
      .clk, .rst, .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata,
      .cfg (cfg_if.regs),
      .sts (sts_if.regs)
   );

   hb_sequencer u_seq (
      .clk, .rst, .mem_req, .mem_we, .mem_addr,
      .mem_busy, .mem_done, .mem_err, .cs0n, .ck_en, .dq_out_en, .wds_en,
      .load, .ca_step, .data_step, .data_sel, .capture, .word_full,
      .cfg (cfg_if.seq),
      .sts (sts_if.seq)
   );

   hb_tx_path u_tx (
      .clk, .rst, .load, .ca_step, .data_step, .data_sel,
      .mem_we, .mem_addr, .mem_wdata, .mem_wstrb,
      .dq_out0, .dq_out1, .wds0, .wds1
   );

   hb_rx_path u_rx (
      .clk, .rst, .capture, .dq_in, .rwds_in, .word_full, .mem_rdata
   );

endmodule

`default_nettype wire

// ==== logic/hb_pkg.sv ====
`default_nettype none

package hb_pkg;

`include "hb_settings.svh"

   typedef logic [`HB_ADDR_W-1:0]   mem_addr_t;
   typedef logic [`HB_DATA_W-1:0]   mem_word_t;
   typedef logic [`HB_DATA_W/8-1:0] byte_strb_t;
   typedef logic [`HB_TIMING_W-1:0] timing_t;

   // Command-address word, sent MSB first
   typedef struct packed {
      logic        rw;        // 1 read, 0 write
      logic        space;     // 0 memory space
      logic        linear;    // 1 linear burst
      logic [28:0] addr_hi;   // Half-word address bits 31..3
      logic [12:0] rsvd;
      logic [2:0]  addr_lo;   // Half-word address bits 2..0
   } ca_t;

   typedef enum logic [2:0] {
      idle, cs_setup, cmd_addr, latency, data, cs_hold, cs_idle
   } phase_t;

endpackage

`default_nettype wire

// ==== logic/hb_reg_block.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hb_settings.svh"

module hb_reg_block import hb_pkg::*; (
   input  logic            clk,
   input  logic            rst,
   input  logic            reg_wr,
   input  logic            reg_rd,
   input  logic [7:0]      reg_addr,
   input  mem_word_t       reg_wdata,
   output mem_word_t       reg_rdata,
   hb_config_if.regs       cfg,
   hb_status_if.regs       sts
);
   localparam mem_word_t MBR_RST  = `HB_MBR_RESET;
   localparam mem_word_t MTR_MASK = 32'hffff_ff0f;   // Bits 7..4 unused

   logic [7:0] base_q;
   mem_word_t  mtr_q;
   logic       rd_dec_q;
   logic       wr_dec_q;
   logic       sts_wr;
   mem_word_t  rd_mux;

   assign sts_wr = reg_wr && (reg_addr == `HB_REG_STS);

   // ----------------------------------------
   // Configuration and sticky status
   always_ff @(posedge clk) begin
      if (rst) begin
         base_q   <= MBR_RST[31:24];
         mtr_q    <= `HB_MTR_RESET;
         rd_dec_q <= 1'b0;
         wr_dec_q <= 1'b0;
      end else begin
         if (reg_wr && (reg_addr == `HB_REG_MBR)) base_q <= reg_wdata[31:24];
         if (reg_wr && (reg_addr == `HB_REG_MTR)) mtr_q <= reg_wdata & MTR_MASK;
         // New event wins over a clear in the same cycle
         wr_dec_q <= (wr_dec_q && !(sts_wr && reg_wdata[8])) || sts.wr_dec;
         rd_dec_q <= (rd_dec_q && !(sts_wr && reg_wdata[9])) || sts.rd_dec;
      end
   end

   always_comb begin
      case (reg_addr)
         `HB_REG_MBR: rd_mux = {base_q, 24'h0};
         `HB_REG_MTR: rd_mux = mtr_q;
         `HB_REG_STS: rd_mux = {22'h0, rd_dec_q, wr_dec_q, 6'h0, sts.wr_active, sts.rd_active};
         default:     rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reg_rd) reg_rdata <= rd_mux;
   end

   // ----------------------------------------
   // Timing fields to the sequencer
   assign cfg.base    = base_q;
   assign cfg.rd_cshi = mtr_q[31:28];
   assign cfg.wr_cshi = mtr_q[27:24];
   assign cfg.rd_css  = mtr_q[23:20];
   assign cfg.wr_css  = mtr_q[19:16];
   assign cfg.rd_csh  = mtr_q[15:12];
   assign cfg.wr_csh  = mtr_q[11:8];
   assign cfg.latency = mtr_q[3:0];

endmodule

`default_nettype wire

// ==== logic/hb_rx_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module hb_rx_path import hb_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       capture,
   input  logic [7:0] dq_in,
   input  logic       rwds_in,
   output logic       word_full,
   output mem_word_t  mem_rdata
);
   logic       take;
   logic [1:0] byte_cnt;   // Bytes collected so far

   assign take      = capture && rwds_in;
   assign word_full = take && (byte_cnt == 2'd3);

   // Wraps to zero with the fourth byte
   always_ff @(posedge clk) begin
      if (rst) byte_cnt <= '0;
      else if (take) byte_cnt <= byte_cnt + 1'b1;
   end

   // Most significant byte arrives first
   always_ff @(posedge clk) begin
      if (take) mem_rdata <= {mem_rdata[23:0], dq_in};
   end

endmodule

`default_nettype wire

// ==== logic/hb_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hb_settings.svh"

module hb_sequencer import hb_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      mem_req,
   input  logic      mem_we,
   input  mem_addr_t mem_addr,
   output logic      mem_busy,
   output logic      mem_done,
   output logic      mem_err,
   output logic      cs0n,
   output logic      ck_en,
   output logic      dq_out_en,
   output logic      wds_en,
   output logic      load,
   output logic      ca_step,
   output logic      data_step,
   output logic      data_sel,
   output logic      capture,
   input  logic      word_full,
   hb_config_if.seq  cfg,
   hb_status_if.seq  sts
);
   localparam timing_t CA_LAST   = timing_t'(`HB_CA_BEATS - 1);
   localparam timing_t DATA_LAST = timing_t'(`HB_DATA_BEATS - 1);

   phase_t  phase;
   timing_t cnt;          // Shared phase down-counter
   logic    we_q;
   logic    err_q;
   logic    accept;
   logic    hit;
   logic    dir;
   timing_t css_sel;
   timing_t csh_sel;
   timing_t cshi_sel;

   assign accept = (phase == idle) && mem_req && !mem_busy;
   assign hit    = (mem_addr[31:24] == cfg.base);
   assign dir    = (phase == idle) ? mem_we : we_q;   // Direction of current access

   assign css_sel  = dir ? cfg.wr_css  : cfg.rd_css;
   assign csh_sel  = dir ? cfg.wr_csh  : cfg.rd_csh;
   assign cshi_sel = dir ? cfg.wr_cshi : cfg.rd_cshi;

   // ----------------------------------------
   // Phase walk
   always_ff @(posedge clk) begin
      if (rst) begin
         phase <= idle;
         cnt   <= '0;
         we_q  <= 1'b0;
         err_q <= 1'b0;
      end else begin
         err_q <= accept && !hit;
         if (accept) we_q <= mem_we;
         case (phase)
            idle: if (accept && hit) begin
               phase <= cs_setup;
               cnt   <= css_sel;
            end
            cs_setup: if (cnt == 0) begin
               phase <= cmd_addr;
               cnt   <= CA_LAST;
            end else cnt <= cnt - 1'b1;
            cmd_addr: if (cnt != 0) begin
               cnt <= cnt - 1'b1;
            end else if (cfg.latency == 0) begin
               phase <= data;                      // No latency cycles
               cnt   <= DATA_LAST;
            end else begin
               phase <= latency;
               cnt   <= cfg.latency - 1'b1;
            end
            latency: if (cnt == 0) begin
               phase <= data;
               cnt   <= DATA_LAST;
            end else cnt <= cnt - 1'b1;
            data: if (we_q ? (cnt == 0) : word_full) begin
               phase <= cs_hold;
               cnt   <= csh_sel;
            end else if (we_q) cnt <= cnt - 1'b1;  // Read length set by rx path
            cs_hold: if (cnt == 0) begin
               phase <= cs_idle;
               cnt   <= cshi_sel;
            end else cnt <= cnt - 1'b1;
            cs_idle: if (cnt == 0) phase <= idle;
            else cnt <= cnt - 1'b1;
            default: phase <= idle;
         endcase
      end
   end

   // ----------------------------------------
   // Bus and handshake levels
   assign mem_busy  = (phase != idle) || err_q;
   assign mem_done  = err_q || ((phase == cs_idle) && (cnt == 0));
   assign mem_err   = err_q;
   assign cs0n      = (phase == idle) || (phase == cs_idle);
   assign ck_en     = (phase == cmd_addr) || (phase == latency) || (phase == data);
   assign dq_out_en = (phase == cmd_addr) || ((phase == data) && we_q);
   assign wds_en    = (phase == data) && we_q;

   assign load      = accept;
   assign ca_step   = (phase == cmd_addr);
   assign data_step = (phase == data) && we_q;
   assign data_sel  = (phase == data) && we_q;
   assign capture   = (phase == data) && !we_q;

   assign sts.rd_active = (phase != idle) && !we_q;
   assign sts.wr_active = (phase != idle) && we_q;
   assign sts.rd_dec    = err_q && !we_q;
   assign sts.wr_dec    = err_q && we_q;

endmodule

`default_nettype wire

// ==== logic/hb_status_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface hb_status_if;
   logic rd_active;   // Level over whole transaction
   logic wr_active;
   logic rd_dec;      // One-cycle decode error pulses
   logic wr_dec;

   modport seq  (output rd_active, wr_active, rd_dec, wr_dec);
   modport regs (input rd_active, wr_active, rd_dec, wr_dec);
endinterface

`default_nettype wire

// ==== logic/hb_tx_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module hb_tx_path import hb_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       load,
   input  logic       ca_step,
   input  logic       data_step,
   input  logic       data_sel,
   input  logic       mem_we,
   input  mem_addr_t  mem_addr,
   input  mem_word_t  mem_wdata,
   input  byte_strb_t mem_wstrb,
   output logic [7:0] dq_out0,
   output logic [7:0] dq_out1,
   output logic       wds0,
   output logic       wds1
);
   ca_t        ca_next;
   ca_t        ca_sr;
   mem_word_t  data_sr;
   byte_strb_t mask_sr;   // High for a masked byte

   always_comb begin
      ca_next         = '0;
      ca_next.rw      = !mem_we;
      ca_next.space   = 1'b0;
      ca_next.linear  = 1'b1;
      ca_next.addr_hi = {1'b0, mem_addr[31:4]};
      ca_next.addr_lo = mem_addr[3:1];
   end

   // ----------------------------------------
   // Shift by one byte pair per step
   always_ff @(posedge clk) begin
      if (load) begin
         ca_sr   <= ca_next;
         data_sr <= mem_wdata;
      end else begin
         if (ca_step)   ca_sr   <= {ca_sr[31:0], 16'h0};
         if (data_step) data_sr <= {data_sr[15:0], 16'h0};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) mask_sr <= '0;
      else if (load) mask_sr <= ~mem_wstrb;
      else if (data_step) mask_sr <= {mask_sr[1:0], 2'b00};
   end

   assign dq_out0 = data_sel ? data_sr[31:24] : ca_sr[47:40];   // MSB first
   assign dq_out1 = data_sel ? data_sr[23:16] : ca_sr[39:32];
   assign wds0    = mask_sr[3];
   assign wds1    = mask_sr[2];

endmodule

`default_nettype wire

// ==== test/hb_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hb_settings.svh"

module hb_ctrl_tb import hb_pkg::*; ();
   localparam int        RST_CYCLES = 10;
   localparam mem_addr_t MBR_OFS    = 32'(`HB_REG_MBR);
   localparam mem_addr_t MTR_OFS    = 32'(`HB_REG_MTR);
   localparam mem_addr_t STS_OFS    = 32'(`HB_REG_STS);
   localparam mem_addr_t NONE_OFS   = 32'h0000_000c;   // Unmapped

   typedef enum logic [1:0] {reg_write, reg_read, mem_write, mem_read} op_t;
   typedef struct {
      op_t        op;
      mem_addr_t  addr;
      mem_word_t  data;
      byte_strb_t strb;
      mem_word_t  exp;
   } entry_t;

   logic clk, rst, mem_req, mem_we, reg_wr, reg_rd, rwds_in, exp_rw;
   logic mem_busy, mem_done, mem_err, cs0n, ck_en, dq_out_en, wds_en, wds0, wds1;
   logic [7:0] reg_addr, dq_in, dq_out0, dq_out1;
   logic [3:0] lat;
   mem_addr_t  mem_addr, exp_addr;
   mem_word_t  mem_wdata, mem_rdata, reg_wdata, reg_rdata, mtr_sh;
   byte_strb_t mem_wstrb;
   logic [7:0] base_sh;
   logic [31:0] lfsr;
   int model_errors, txn_cnt, setup_cnt, hold_cnt, errors, checks, cycles;
   entry_t     tbl [$];
   mem_word_t  shadow [mem_addr_t];

   hb_ctrl_top DUT (.*);

   hb_mem_model u_model (.clk, .cs0n, .ck_en, .dq_out_en, .dq_out0, .dq_out1, .wds_en,
      .wds0, .wds1, .exp_rw, .exp_addr, .lat, .dq_in, .rwds_in, .errors(model_errors),
      .txn_cnt, .setup_cnt, .hold_cnt);

   always #20 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);   // Galois form
   endfunction

   task automatic draw_word(output mem_word_t w);
      w = '0;
      for (int i = 0; i < 32; i++) begin
         w    = {w[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic report_mismatch(input string name, input mem_word_t got, input mem_word_t ev);
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, ev);
   endtask

   task automatic add_entry(input op_t op, input mem_addr_t a, input mem_word_t dv,
                            input byte_strb_t s, input mem_word_t ev);
      entry_t e;
      e = '{op, a, dv, s, ev};
      tbl.push_back(e);
   endtask

   // Busy holds from the cycle after acceptance through done
   task automatic check_busy_cycle(input logic err_exp);
      if (mem_busy !== 1'b1) report_mismatch("mem_busy", {31'h0, mem_busy}, 32'h1);
      if (err_exp && cs0n !== 1'b1) report_mismatch("cs0n", {31'h0, cs0n}, 32'h1);
   endtask

   // ----------------------------------------
   task automatic reg_access(input entry_t e);
      @(negedge clk);
      reg_addr  = e.addr[7:0];
      reg_wdata = e.data;
      reg_wr    = (e.op == reg_write);
      reg_rd    = (e.op == reg_read);
      @(negedge clk);
      reg_wr = 1'b0;
      reg_rd = 1'b0;
      if (e.op == reg_write) begin
         if (e.addr == MBR_OFS) base_sh = e.data[31:24];
         if (e.addr == MTR_OFS) mtr_sh = e.data;
      end else begin
         checks++;
         if (reg_rdata !== e.exp) report_mismatch("reg_rdata", reg_rdata, e.exp);
      end
   endtask

   task automatic mem_access(input entry_t e);
      logic      we;
      logic      err_exp;
      int        txn_before;
      int        setup_exp;
      int        hold_exp;
      mem_word_t wd;
      mem_word_t sh;
      we         = (e.op == mem_write);
      err_exp    = (e.addr[31:24] != base_sh);   // Decode rule on bits 31..24
      setup_exp  = int'(we ? mtr_sh[19:16] : mtr_sh[23:20]) + 1;   // Setup field of the direction
      hold_exp   = int'(we ? mtr_sh[11:8] : mtr_sh[15:12]) + 1;
      wd         = e.data;
      txn_before = txn_cnt;
      if (we) draw_word(wd);
      @(negedge clk);
      if (mem_busy !== 1'b0) report_mismatch("mem_busy", {31'h0, mem_busy}, 32'h0);
      exp_rw    = !we;
      exp_addr  = e.addr;
      lat       = mtr_sh[3:0];
      mem_req   = 1'b1;
      mem_we    = we;
      mem_addr  = e.addr;
      mem_wdata = wd;
      mem_wstrb = e.strb;
      @(negedge clk);
      mem_req = 1'b0;
      check_busy_cycle(err_exp);
      while (!mem_done) begin
         @(negedge clk);
         check_busy_cycle(err_exp);
      end
      checks++;
      if (mem_err !== err_exp) report_mismatch("mem_err", {31'h0, mem_err}, {31'h0, err_exp});
      if (!err_exp) begin
         if (txn_cnt != txn_before + 1) begin
            errors++;
            $display("memory model saw no command-address for the access at %0t", $time);
         end
         if (setup_cnt != setup_exp) report_mismatch("setup cycles", setup_cnt, setup_exp);
         if (hold_cnt != hold_exp) report_mismatch("hold cycles", hold_cnt, hold_exp);
         if (we) begin
            sh = shadow.exists(e.addr) ? shadow[e.addr] : '0;
            for (int i = 0; i < 4; i++) begin
               if (e.strb[i]) sh[8*i +: 8] = wd[8*i +: 8];   // Only strobed bytes
            end
            shadow[e.addr] = sh;
         end else if (mem_rdata !== shadow[e.addr]) begin
            report_mismatch("mem_rdata", mem_rdata, shadow[e.addr]);
         end
      end
   endtask

   // ----------------------------------------
   task automatic build_table();
      add_entry(reg_read,  MTR_OFS,  0, 4'h0, `HB_MTR_RESET);
      add_entry(reg_read,  MBR_OFS,  0, 4'h0, `HB_MBR_RESET);
      add_entry(reg_read,  NONE_OFS, 0, 4'h0, 0);
      add_entry(reg_write, MBR_OFS,  32'h4000_0000, 4'h0, 0);
      add_entry(reg_read,  MBR_OFS,  0, 4'h0, 32'h4000_0000);
      add_entry(reg_write, MTR_OFS,  32'h1231_4504, 4'h0, 0);   // rcss 3, wcss 1, lat 4
      add_entry(reg_read,  MTR_OFS,  0, 4'h0, 32'h1231_4504);
      add_entry(mem_write, 32'h4000_0100, 0, 4'hf, 0);
      add_entry(mem_read,  32'h4000_0100, 0, 4'h0, 0);
      add_entry(mem_write, 32'h4000_0100, 0, 4'h5, 0);
      add_entry(mem_read,  32'h4000_0100, 0, 4'h0, 0);
      add_entry(mem_write, 32'h4012_3458, 0, 4'hf, 0);
      add_entry(mem_write, 32'h4012_3458, 0, 4'ha, 0);
      add_entry(mem_read,  32'h4012_3458, 0, 4'h0, 0);
      add_entry(reg_write, MTR_OFS,  32'h2103_2102, 4'h0, 0);   // rcss 0, wcss 3, lat 2
      add_entry(mem_write, 32'h40ff_fffc, 0, 4'hf, 0);
      add_entry(mem_write, 32'h40ff_fffc, 0, 4'h9, 0);
      add_entry(mem_read,  32'h40ff_fffc, 0, 4'h0, 0);
      add_entry(mem_read,  32'h4000_0100, 0, 4'h0, 0);
      add_entry(mem_write, 32'h0000_0200, 0, 4'hf, 0);          // Outside base
      add_entry(reg_read,  STS_OFS,  0, 4'h0, 32'h0000_0100);
      add_entry(reg_write, STS_OFS,  32'h0000_0100, 4'h0, 0);
      add_entry(reg_read,  STS_OFS,  0, 4'h0, 0);
      add_entry(mem_read,  32'h8000_0000, 0, 4'h0, 0);
      add_entry(reg_read,  STS_OFS,  0, 4'h0, 32'h0000_0200);
      add_entry(reg_write, STS_OFS,  32'h0000_0200, 4'h0, 0);
      add_entry(reg_read,  STS_OFS,  0, 4'h0, 0);
   endtask

   initial begin
      clk       = 1'b0;
      rst       = 1'b1;
      mem_req   = 1'b0;
      mem_we    = 1'b0;
      mem_addr  = '0;
      mem_wdata = '0;
      mem_wstrb = '0;
      reg_wr    = 1'b0;
      reg_rd    = 1'b0;
      reg_addr  = '0;
      reg_wdata = '0;
      exp_rw    = 1'b0;
      exp_addr  = '0;
      lat       = 4'd6;
      lfsr      = 32'h0b04_58ac;
      base_sh   = 8'h00;
      mtr_sh    = `HB_MTR_RESET;
      build_table();
      repeat (RST_CYCLES) @(negedge clk);
      rst = 1'b0;
      foreach (tbl[i]) begin
         if (tbl[i].op == reg_write || tbl[i].op == reg_read) reg_access(tbl[i]);
         else mem_access(tbl[i]);
      end
      $display("%0d checks, %0d testbench errors, %0d model errors", checks, errors,
               model_errors);
      if (errors == 0 && model_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // Run limit grows with the table
   initial begin
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (cycles < tbl.size() * 100 + RST_CYCLES);
      $display("run stopped after %0d cycles, the DUT did not finish the table", cycles);
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/hb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hb_settings.svh"

module hb_mem_model (
   input  logic        clk,
   input  logic        cs0n,
   input  logic        ck_en,
   input  logic        dq_out_en,
   input  logic [7:0]  dq_out0,
   input  logic [7:0]  dq_out1,
   input  logic        wds_en,
   input  logic        wds0,
   input  logic        wds1,
   input  logic        exp_rw,     // Direction the testbench expects, 1 read
   input  logic [31:0] exp_addr,
   input  logic [3:0]  lat,
   output logic [7:0]  dq_in,
   output logic        rwds_in,
   output int          errors,
   output int          txn_cnt,
   output int          setup_cnt,
   output int          hold_cnt
);
   logic [7:0]  mem [logic [31:0]];
   logic [47:0] ca;
   logic [47:0] ca_w;
   logic [31:0] base;      // Word byte address of the access
   bit          active;
   bit          is_rd;
   int          beat;      // Clocked cycles seen in this access
   int          wbeat;
   int          d;
   int          k;

   function automatic logic [7:0] read_byte(input logic [31:0] a);
      if (mem.exists(a)) return mem[a];
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;   // Fill for unwritten bytes
   endfunction

   task automatic check_ca(input logic [47:0] w);
      logic [31:0] hw;
      hw = {w[44:16], w[2:0]};
      txn_cnt = txn_cnt + 1;
      if (w[47] !== exp_rw) begin
         errors = errors + 1;
         $display("mismatch at %0t: ca rw got %b expected %b", $time, w[47], exp_rw);
      end
      if (hw !== {1'b0, exp_addr[31:1]}) begin
         errors = errors + 1;
         $display("mismatch at %0t: ca address got %h expected %h", $time, hw,
                  {1'b0, exp_addr[31:1]});
      end
      if (w[46] !== 1'b0 || w[45] !== 1'b1 || w[15:3] !== '0) begin
         errors = errors + 1;
         $display("malformed command-address space, burst or reserved bits at %0t", $time);
      end
   endtask

   // ----------------------------------------
   // Read bytes, one idle cycle after the second
   always_comb begin
      d       = beat - `HB_CA_BEATS - int'(lat);
      k       = (d > 2) ? d - 1 : d;
      rwds_in = 1'b0;
      dq_in   = 8'h00;
      if (!cs0n && ck_en && is_rd && (d == 0 || d == 1 || d == 3 || d == 4)) begin
         rwds_in = 1'b1;
         dq_in   = read_byte(base + 32'(3 - k));   // MSB first
      end
   end

   always @(posedge clk) begin
      if (cs0n) begin
         active <= 1'b0;
      end else if (!active) begin
         active    <= 1'b1;   // First setup cycle
         is_rd     <= 1'b0;
         beat      <= 0;
         wbeat     <= 0;
         setup_cnt = 1;
         hold_cnt  = 0;
      end else if (ck_en) begin
         beat <= beat + 1;
         if (beat < `HB_CA_BEATS) begin
            if (!dq_out_en) begin
               errors = errors + 1;
               $display("dq_out_en low during a command-address cycle at %0t", $time);
            end
            ca_w = {ca[31:0], dq_out0, dq_out1};
            ca <= ca_w;
            if (beat == `HB_CA_BEATS - 1) begin
               check_ca(ca_w);
               is_rd <= ca_w[47];
               base  <= {ca_w[43:16], ca_w[2:0], 1'b0};
            end
         end
         if (wds_en) begin
            if (!wds0) mem[base + 32'(3 - 2 * wbeat)] = dq_out0;
            if (!wds1) mem[base + 32'(2 - 2 * wbeat)] = dq_out1;
            wbeat <= wbeat + 1;
         end
      end else if (beat == 0) begin
         setup_cnt = setup_cnt + 1;
      end else begin
         hold_cnt = hold_cnt + 1;
      end
   end

endmodule

`default_nettype wire
